// File: rtl/coreid.sv
`timescale 1ns/1ps

module coreid
  import zxuno_pkg::*;
#(
  parameter logic [63:0] CORE_ID = "ZXUNO-IO",
  parameter int          ID_LEN  = 8
) (
  input  logic      sysclk,
  input  logic      rst,
  input  reg_addr_t reg_addr,
  input  logic      reg_rd,
  input  logic      reg_rd_stb,
  input  logic      regaddr_changed,
  output zx_data_t  dout,
  output logic      oe
);

  // Index runs 0..ID_LEN, ID_LEN meaning string exhausted
  logic [3:0]  char_idx;
  logic [2:0]  char_sel;
  logic [63:0] id_shifted;
  logic        selected;
  logic        more_chars;
  zx_data_t    char_q;

  assign selected   = (reg_addr == REG_COREID);
  assign more_chars = (char_idx < 4'(ID_LEN));

  // First character sits in the highest used byte
  assign char_sel   = 3'(ID_LEN - 1) - char_idx[2:0];
  assign id_shifted = CORE_ID >> {char_sel, 3'b000};

  always_ff @(posedge sysclk) begin
    if (rst)
      char_idx <= '0;
    else if (regaddr_changed)
      char_idx <= '0;
    else if (reg_rd_stb && selected && more_chars)
      char_idx <= char_idx + 4'd1;
  end

  // Byte latched at the start of the read
  always_ff @(posedge sysclk) begin
    if (reg_rd_stb && selected) begin
      if (more_chars)
        char_q <= id_shifted[7:0];
      else
        char_q <= '0;
    end
  end

  assign dout = char_q;
  assign oe   = reg_rd && selected;

  a_idx_in_range: assert property (@(posedge sysclk) disable iff (rst)
    char_idx <= 4'(ID_LEN));

endmodule

// File: rtl/cpu_bus_mux.sv
`timescale 1ns/1ps

module cpu_bus_mux
  import zxuno_pkg::*;
(
  input  logic     iorq_n,
  input  logic     m1_n,
  input  zx_data_t addr_dout,
  input  logic     oe_addr,
  input  zx_data_t coreid_dout,
  input  logic     oe_coreid,
  input  zx_data_t scratch_dout,
  input  logic     oe_scratch,
  input  zx_data_t devopt_dout,
  input  logic     oe_devopt,
  input  zx_data_t scndbl_dout,
  input  logic     oe_scndbl,
  output zx_data_t dout
);

  logic oe_intack;

  // Interrupt acknowledge cycle
  assign oe_intack = !iorq_n && !m1_n;

  always_comb begin
    case (1'b1)
      oe_intack:  dout = INTACK_DATA;
      oe_addr:    dout = addr_dout;
      oe_coreid:  dout = coreid_dout;
      oe_scratch: dout = scratch_dout;
      oe_devopt:  dout = devopt_dout;
      oe_scndbl:  dout = scndbl_dout;
      default:    dout = BUS_IDLE_DATA;
    endcase
  end

  // Each block decodes its own register number
  always_comb begin
    a_one_block: assert ($onehot0({oe_coreid, oe_scratch, oe_devopt, oe_scndbl}));
  end

endmodule

// File: rtl/option_registers.sv
`timescale 1ns/1ps

module option_registers
  import zxuno_pkg::*;
(
  input  logic      sysclk,
  input  logic      rst,
  input  reg_addr_t reg_addr,
  input  logic      reg_rd,
  input  logic      reg_wr_stb,
  input  zx_data_t  din,
  output zx_data_t  scratch_dout,
  output logic      oe_scratch,
  output zx_data_t  devopt_dout,
  output logic      oe_devopt,
  output devopt_t   devoptions
);

  // Plain read/write bytes, slot 0 scratch, slot 1 device options
  localparam int NREGS = 2;
  localparam reg_addr_t REG_NUM [NREGS] = '{REG_SCRATCH, REG_DEVOPTIONS};

  zx_data_t         regs [NREGS];
  logic [NREGS-1:0] sel;

  always_comb begin
    for (int i = 0; i < NREGS; i++)
      sel[i] = (reg_addr == REG_NUM[i]);
  end

  always_ff @(posedge sysclk) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++)
        regs[i] <= '0;
    end else if (reg_wr_stb) begin
      for (int i = 0; i < NREGS; i++) begin
        if (sel[i])
          regs[i] <= din;
      end
    end
  end

  // ----------------------------------------------------------
  // Readback and option lines
  // ----------------------------------------------------------

  assign scratch_dout = regs[0];
  assign oe_scratch   = reg_rd && sel[0];

  assign devopt_dout  = regs[1];
  assign oe_devopt    = reg_rd && sel[1];

  // Bit 0 disable_ay
  // Bit 1 disable_turboay
  // Bit 2 disable_7ffd
  // Bit 3 disable_1ffd
  // Bit 4 disable_romsel7f
  // Bit 5 disable_romsel1f
  // Bit 6 enable_timexmmu
  // Bit 7 disable_spisd
  assign devoptions   = regs[1];

endmodule

// File: rtl/scandoubler_ctrl.sv
`timescale 1ns/1ps

module scandoubler_ctrl
  import zxuno_pkg::*;
(
  input  logic         sysclk,
  input  logic         rst,
  input  reg_addr_t    reg_addr,
  input  logic         reg_rd,
  input  logic         reg_wr_stb,
  input  zx_data_t     din,
  input  logic         turbo_boost,
  input  logic         video_output_change,
  output zx_data_t     dout,
  output logic         oe,
  output logic         vga_enable,
  output logic         scanlines_enable,
  output logic         csync_option,
  output freq_option_t freq_option,
  output cpu_speed_t   cpu_speed
);

  zx_data_t ctrl;
  logic     selected;
  logic     ctrl_wr;

  assign selected = (reg_addr == REG_SCANDBLCTRL);
  assign ctrl_wr  = reg_wr_stb && selected;

  // CPU write beats the keyboard toggle
  always_ff @(posedge sysclk) begin
    if (rst)
      ctrl <= '0;
    else if (ctrl_wr)
      ctrl <= din;
    else if (video_output_change)
      ctrl[0] <= ~ctrl[0];
  end

  // ----------------------------------------------------------
  // Field decode
  // ----------------------------------------------------------

  assign vga_enable       = ctrl[0];
  assign scanlines_enable = ctrl[1];
  assign freq_option      = ctrl[4:2];
  assign csync_option     = ctrl[5];

  // Boost key overrides the speed but leaves the stored bits alone
  assign cpu_speed = turbo_boost ? TURBO_SPEED : ctrl[7:6];

  assign dout = ctrl;
  assign oe   = reg_rd && selected;

  a_write_beats_toggle: assert property (@(posedge sysclk) disable iff (rst)
    (ctrl_wr && video_output_change) |=> (ctrl == $past(din)));

endmodule

// File: rtl/zxuno_io.sv
`timescale 1ns/1ps

module zxuno_io
  import zxuno_pkg::*;
#(
  parameter logic [63:0] CORE_ID = "ZXUNO-IO",
  parameter int          ID_LEN  = 8
) (
  input  logic         sysclk,
  input  logic         rst,
  input  zx_addr_t     a,
  input  zx_data_t     din,
  input  logic         iorq_n,
  input  logic         rd_n,
  input  logic         wr_n,
  input  logic         m1_n,
  input  logic         turbo_boost,
  input  logic         video_output_change,
  output zx_data_t     dout,
  output logic         vga_enable,
  output logic         scanlines_enable,
  output logic         csync_option,
  output freq_option_t freq_option,
  output cpu_speed_t   cpu_speed,
  output devopt_t      devoptions
);

  // Register bus from the decoder
  reg_addr_t reg_addr;
  logic      reg_rd;
  logic      reg_rd_stb;
  logic      reg_wr_stb;
  logic      regaddr_changed;

  // Read bytes and enables into the mux
  zx_data_t addr_dout;
  logic     oe_addr;
  zx_data_t coreid_dout;
  logic     oe_coreid;
  zx_data_t scratch_dout;
  logic     oe_scratch;
  zx_data_t devopt_dout;
  logic     oe_devopt;
  zx_data_t scndbl_dout;
  logic     oe_scndbl;

  // An IORQ with M1 low is an interrupt acknowledge, never a port access
  zxuno_port_decoder port_decoder (
    .sysclk          (sysclk),
    .rst             (rst),
    .a               (a),
    .din             (din),
    .iorq_n          (iorq_n | ~m1_n),
    .rd_n            (rd_n),
    .wr_n            (wr_n),
    .reg_addr        (reg_addr),
    .reg_rd          (reg_rd),
    .reg_rd_stb      (reg_rd_stb),
    .reg_wr_stb      (reg_wr_stb),
    .regaddr_changed (regaddr_changed),
    .addr_dout       (addr_dout),
    .oe_addr         (oe_addr)
  );

  coreid #(
    .CORE_ID (CORE_ID),
    .ID_LEN  (ID_LEN)
  ) core_identification (
    .sysclk          (sysclk),
    .rst             (rst),
    .reg_addr        (reg_addr),
    .reg_rd          (reg_rd),
    .reg_rd_stb      (reg_rd_stb),
    .regaddr_changed (regaddr_changed),
    .dout            (coreid_dout),
    .oe              (oe_coreid)
  );

  option_registers options (
    .sysclk       (sysclk),
    .rst          (rst),
    .reg_addr     (reg_addr),
    .reg_rd       (reg_rd),
    .reg_wr_stb   (reg_wr_stb),
    .din          (din),
    .scratch_dout (scratch_dout),
    .oe_scratch   (oe_scratch),
    .devopt_dout  (devopt_dout),
    .oe_devopt    (oe_devopt),
    .devoptions   (devoptions)
  );

  scandoubler_ctrl scandoubler_control (
    .sysclk              (sysclk),
    .rst                 (rst),
    .reg_addr            (reg_addr),
    .reg_rd              (reg_rd),
    .reg_wr_stb          (reg_wr_stb),
    .din                 (din),
    .turbo_boost         (turbo_boost),
    .video_output_change (video_output_change),
    .dout                (scndbl_dout),
    .oe                  (oe_scndbl),
    .vga_enable          (vga_enable),
    .scanlines_enable    (scanlines_enable),
    .csync_option        (csync_option),
    .freq_option         (freq_option),
    .cpu_speed           (cpu_speed)
  );

  cpu_bus_mux data_in_mux (
    .iorq_n       (iorq_n),
    .m1_n         (m1_n),
    .addr_dout    (addr_dout),
    .oe_addr      (oe_addr),
    .coreid_dout  (coreid_dout),
    .oe_coreid    (oe_coreid),
    .scratch_dout (scratch_dout),
    .oe_scratch   (oe_scratch),
    .devopt_dout  (devopt_dout),
    .oe_devopt    (oe_devopt),
    .scndbl_dout  (scndbl_dout),
    .oe_scndbl    (oe_scndbl),
    .dout         (dout)
  );

endmodule

// File: rtl/zxuno_pkg.sv
package zxuno_pkg;

  // ----------------------------------------------------------
  // Bus and register field widths
  // ----------------------------------------------------------

  typedef logic [15:0] zx_addr_t;
  typedef logic [7:0]  zx_data_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [1:0]  cpu_speed_t;
  typedef logic [2:0]  freq_option_t;
  typedef logic [7:0]  devopt_t;

  // ----------------------------------------------------------
  // Port addresses and register numbers
  // ----------------------------------------------------------

  // Register select and register data ports
  localparam zx_addr_t ZXUNO_ADDR_PORT = 16'hFC3B;
  localparam zx_addr_t ZXUNO_DATA_PORT = 16'hFD3B;

  localparam reg_addr_t REG_COREID      = 8'hFF;
  localparam reg_addr_t REG_SCRATCH     = 8'hFE;
  localparam reg_addr_t REG_DEVOPTIONS  = 8'h0E;
  localparam reg_addr_t REG_SCANDBLCTRL = 8'h0B;

  // Floating bus and interrupt vector byte
  localparam zx_data_t BUS_IDLE_DATA = 8'hFF;
  localparam zx_data_t INTACK_DATA   = 8'hFF;

  // Fastest CPU clock setting
  localparam cpu_speed_t TURBO_SPEED = 2'b11;

  // ----------------------------------------------------------
  // Bus access tracking
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    PHASE_IDLE,
    PHASE_READ,
    PHASE_WRITE
  } bus_phase_t;

endpackage

// File: rtl/zxuno_port_decoder.sv
`timescale 1ns/1ps

module zxuno_port_decoder
  import zxuno_pkg::*;
(
  input  logic      sysclk,
  input  logic      rst,
  input  zx_addr_t  a,
  input  zx_data_t  din,
  input  logic      iorq_n,
  input  logic      rd_n,
  input  logic      wr_n,
  output reg_addr_t reg_addr,
  output logic      reg_rd,
  output logic      reg_rd_stb,
  output logic      reg_wr_stb,
  output logic      regaddr_changed,
  output zx_data_t  addr_dout,
  output logic      oe_addr
);

  bus_phase_t phase;
  bus_phase_t phase_next;

  logic addr_hit;
  logic data_hit;
  logic io_rd;
  logic io_wr;
  logic idle;

  assign addr_hit = (a == ZXUNO_ADDR_PORT);
  assign data_hit = (a == ZXUNO_DATA_PORT);

  // Read wins if rd_n and wr_n are both low
  assign io_rd = !iorq_n && !rd_n && (addr_hit || data_hit);
  assign io_wr = !iorq_n && !wr_n && rd_n && (addr_hit || data_hit);

  // ----------------------------------------------------------
  // Access phase FSM
  // ----------------------------------------------------------

  always_comb begin
    phase_next = phase;
    case (phase)
      PHASE_IDLE: begin
        if (io_rd)
          phase_next = PHASE_READ;
        else if (io_wr)
          phase_next = PHASE_WRITE;
      end
      PHASE_READ: begin
        if (!io_rd)
          phase_next = PHASE_IDLE;
      end
      PHASE_WRITE: begin
        if (!io_wr)
          phase_next = PHASE_IDLE;
      end
      default: phase_next = PHASE_IDLE;
    endcase
  end

  always_ff @(posedge sysclk) begin
    if (rst)
      phase <= PHASE_IDLE;
    else
      phase <= phase_next;
  end

  // Strobes only on the first cycle of an access
  assign idle            = (phase == PHASE_IDLE);
  assign reg_rd_stb      = idle && io_rd && data_hit;
  assign reg_wr_stb      = idle && io_wr && data_hit;
  assign regaddr_changed = idle && io_wr && addr_hit;
  assign reg_rd          = io_rd && data_hit;

  // Register select, also readable on the address port
  always_ff @(posedge sysclk) begin
    if (rst)
      reg_addr <= '0;
    else if (regaddr_changed)
      reg_addr <= din;
  end

  assign addr_dout = reg_addr;
  assign oe_addr   = io_rd && addr_hit;

  a_rd_wr_exclusive: assert property (@(posedge sysclk) disable iff (rst)
    !(reg_rd_stb && reg_wr_stb));

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_zxuno_io \
  -o sim_zxuno_io

./obj_dir/sim_zxuno_io | tee sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi

// File: sources.f
rtl/zxuno_pkg.sv
rtl/zxuno_port_decoder.sv
rtl/coreid.sv
rtl/option_registers.sv
rtl/scandoubler_ctrl.sv
rtl/cpu_bus_mux.sv
rtl/zxuno_io.sv
test/tb_zxuno_io.sv

// File: test/tb_zxuno_io.sv
`timescale 1ns/1ps

module tb_zxuno_io
  import zxuno_pkg::*;
();

  // Short ID string so the tail of zeros shows up early
  localparam string       ID_TEXT        = "TEST01";
  localparam int          ID_LEN         = 6;
  localparam logic [63:0] CORE_ID        = {16'h0000, "TEST01"};
  localparam int          TOGGLE_TIMEOUT = 10;

  logic         sysclk;
  logic         rst;
  zx_addr_t     a;
  zx_data_t     din;
  logic         iorq_n;
  logic         rd_n;
  logic         wr_n;
  logic         m1_n;
  logic         turbo_boost;
  logic         video_output_change;
  zx_data_t     dout;
  logic         vga_enable;
  logic         scanlines_enable;
  logic         csync_option;
  freq_option_t freq_option;
  cpu_speed_t   cpu_speed;
  devopt_t      devoptions;

  // Reference model state
  reg_addr_t   model_addr;
  zx_data_t    model_scratch;
  zx_data_t    model_devopt;
  zx_data_t    model_ctrl;
  int          model_idx;

  int          errors;
  int          checks;
  int          test_start;
  logic [31:0] rng_state;

  zxuno_io #(
    .CORE_ID (CORE_ID),
    .ID_LEN  (ID_LEN)
  ) UUT (
    .sysclk              (sysclk),
    .rst                 (rst),
    .a                   (a),
    .din                 (din),
    .iorq_n              (iorq_n),
    .rd_n                (rd_n),
    .wr_n                (wr_n),
    .m1_n                (m1_n),
    .turbo_boost         (turbo_boost),
    .video_output_change (video_output_change),
    .dout                (dout),
    .vga_enable          (vga_enable),
    .scanlines_enable    (scanlines_enable),
    .csync_option        (csync_option),
    .freq_option         (freq_option),
    .cpu_speed           (cpu_speed),
    .devoptions          (devoptions)
  );

  initial sysclk = 1'b0;
  always #20 sysclk = ~sysclk;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic zx_data_t id_char(input int idx);
    if (idx < ID_TEXT.len())
      return zx_data_t'(ID_TEXT[idx]);
    return 8'h00;
  endfunction

  function automatic logic is_implemented(input reg_addr_t r);
    return (r == 8'hFF) || (r == 8'hFE) || (r == 8'h0E) || (r == 8'h0B);
  endfunction

  // Byte the CPU should see on a plain port read
  function automatic zx_data_t expected_read(input zx_addr_t port);
    if (port == 16'hFC3B)
      return model_addr;
    if (port != 16'hFD3B)
      return 8'hFF;
    case (model_addr)
      8'hFF:   return id_char(model_idx);
      8'hFE:   return model_scratch;
      8'h0E:   return model_devopt;
      8'h0B:   return model_ctrl;
      default: return 8'hFF;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Bus tasks and checking
  // ----------------------------------------------------------

  task automatic check(input zx_data_t got, input zx_data_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t: %s, got %02h, expected %02h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic next_byte(output zx_data_t v);
    rng_state = xorshift32(rng_state);
    v = rng_state[7:0];
  endtask

  task automatic bus_write(input zx_addr_t port, input zx_data_t val);
    @(posedge sysclk);
    a      <= port;
    din    <= val;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    repeat (3) @(posedge sysclk);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
  endtask

  // Sampled mid-cycle in the third cycle of the access
  task automatic bus_read(input zx_addr_t port, input logic m1, output zx_data_t val);
    @(posedge sysclk);
    a      <= port;
    iorq_n <= 1'b0;
    rd_n   <= 1'b0;
    m1_n   <= m1;
    repeat (2) @(posedge sysclk);
    @(negedge sysclk);
    val = dout;
    @(posedge sysclk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    m1_n   <= 1'b1;
  endtask

  task automatic write_port(input zx_addr_t port, input zx_data_t val);
    bus_write(port, val);
    if (port == 16'hFC3B) begin
      model_addr = val;
      model_idx  = 0;
    end else begin
      case (model_addr)
        8'hFE:   model_scratch = val;
        8'h0E:   model_devopt  = val;
        8'h0B:   model_ctrl    = val;
        default: ;
      endcase
    end
  endtask

  task automatic read_and_compare(input zx_addr_t port, input string msg);
    zx_data_t got;
    zx_data_t exp;
    exp = expected_read(port);
    bus_read(port, 1'b1, got);
    check(got, exp, msg);
    if (port == 16'hFD3B && model_addr == 8'hFF && model_idx < ID_LEN)
      model_idx++;
  endtask

  task automatic check_scandoubler_outputs(input string msg);
    @(negedge sysclk);
    check(8'(vga_enable), 8'(model_ctrl[0]), {msg, " vga_enable"});
    check(8'(scanlines_enable), 8'(model_ctrl[1]), {msg, " scanlines_enable"});
    check(8'(freq_option), 8'(model_ctrl[4:2]), {msg, " freq_option"});
    check(8'(csync_option), 8'(model_ctrl[5]), {msg, " csync_option"});
    check(8'(cpu_speed), 8'(model_ctrl[7:6]), {msg, " cpu_speed"});
  endtask

  task automatic wait_vga_toggle(input logic old);
    int n;
    n = 0;
    while (vga_enable === old && n < TOGGLE_TIMEOUT) begin
      @(negedge sysclk);
      n++;
    end
    if (vga_enable === old) begin
      $display("Timeout: vga_enable did not toggle within %0d cycles", TOGGLE_TIMEOUT);
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, errors - test_start);
    test_start = errors;
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin
    zx_data_t v;
    zx_data_t got;
    logic     old_vga;
    rst                 <= 1'b1;
    a                   <= '0;
    din                 <= '0;
    iorq_n              <= 1'b1;
    rd_n                <= 1'b1;
    wr_n                <= 1'b1;
    m1_n                <= 1'b1;
    turbo_boost         <= 1'b0;
    video_output_change <= 1'b0;
    rng_state     = 32'h578a2005;
    errors        = 0;
    checks        = 0;
    test_start    = 0;
    model_addr    = 8'h00;
    model_scratch = 8'h00;
    model_devopt  = 8'h00;
    model_ctrl    = 8'h00;
    model_idx     = 0;
    repeat (8) @(posedge sysclk);
    rst <= 1'b0;

    check_scandoubler_outputs("after reset");
    check(devoptions, 8'h00, "devoptions after reset");
    read_and_compare(16'hFC3B, "address port after reset");
    read_and_compare(16'hFD3B, "unimplemented register 0x00");
    end_test(1, "reset state");

    for (int i = 0; i < 16; i++) begin
      next_byte(v);
      write_port(16'hFC3B, v);
      read_and_compare(16'hFC3B, "address port readback");
      next_byte(v);
      while (is_implemented(v))
        v = v + 8'd1;
      write_port(16'hFC3B, v);
      read_and_compare(16'hFD3B, $sformatf("unimplemented register %02h", v));
    end
    end_test(2, "address port");

    for (int i = 0; i < 8; i++) begin
      write_port(16'hFC3B, 8'hFE);
      next_byte(v);
      write_port(16'hFD3B, v);
      read_and_compare(16'hFD3B, "scratch readback");
      write_port(16'hFC3B, 8'h0E);
      next_byte(v);
      write_port(16'hFD3B, v);
      read_and_compare(16'hFD3B, "devoptions readback");
      @(negedge sysclk);
      check(devoptions, model_devopt, "devoptions output");
    end
    write_port(16'hFC3B, 8'hFE);
    read_and_compare(16'hFD3B, "scratch after devoptions writes");
    end_test(3, "scratch and devoptions");

    write_port(16'hFC3B, 8'h0B);
    for (int i = 0; i < 4; i++) begin
      next_byte(v);
      write_port(16'hFD3B, v);
      check_scandoubler_outputs("scandoubler write");
      read_and_compare(16'hFD3B, "scandoubler readback");
      old_vga = vga_enable;
      @(posedge sysclk);
      video_output_change <= 1'b1;
      @(posedge sysclk);
      video_output_change <= 1'b0;
      wait_vga_toggle(old_vga);
      model_ctrl[0] = ~model_ctrl[0];
      check_scandoubler_outputs("after video_output_change");
      read_and_compare(16'hFD3B, "readback after video_output_change");
      @(posedge sysclk);
      turbo_boost <= 1'b1;
      @(negedge sysclk);
      check(8'(cpu_speed), 8'h03, "cpu_speed with turbo_boost");
      read_and_compare(16'hFD3B, "readback with turbo_boost");
      @(posedge sysclk);
      turbo_boost <= 1'b0;
      check_scandoubler_outputs("after turbo_boost release");
    end
    end_test(4, "scandoubler control");

    write_port(16'hFC3B, 8'hFF);
    for (int i = 0; i < ID_LEN + 2; i++)
      read_and_compare(16'hFD3B, $sformatf("core id character %0d", i));
    write_port(16'hFC3B, 8'hFF);
    for (int i = 0; i < 2; i++)
      read_and_compare(16'hFD3B, $sformatf("core id restart character %0d", i));
    end_test(5, "core id string");

    // Interrupt acknowledge overrides every port
    // Register 0x0B selected so a plain address port read gives 0x0B
    write_port(16'hFC3B, 8'h0B);
    bus_read(16'hFC3B, 1'b0, got);
    check(got, 8'hFF, "interrupt acknowledge at address port");
    write_port(16'hFC3B, 8'hFF);
    read_and_compare(16'hFD3B, "core id before interrupt acknowledge");
    bus_read(16'hFD3B, 1'b0, got);
    check(got, 8'hFF, "interrupt acknowledge at data port");
    read_and_compare(16'hFD3B, "core id after interrupt acknowledge");
    end_test(6, "interrupt acknowledge");

    $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
